// File: bench/npc_core_assert.sv
// NPC core checker: concurrent assertions on the retire port, the halt level and the PC.

module npc_core_assert (
  input logic             i_clk,
  input logic             i_rst_n,
  input npc_pkg::xlen_t   i_pc,
  input npc_pkg::retire_t i_retire,
  input logic             i_halt
);

  timeunit 1ns;
  timeprecision 100ps;

  a_no_retire_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_retire.en)
    else $error("Retire enable high while reset is asserted.");

  a_no_retire_halted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_halt |-> !i_retire.en)
    else $error("Retire enable high while the core is halted.");

  a_no_x0_retire: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_retire.en |-> (i_retire.rd != 5'd0))
    else $error("Retire names register x0.");

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_pc[1:0] == 2'b00)
    else $error("PC is not word aligned.");

  a_pc_frozen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_halt |=> (i_pc == $past(i_pc)))
    else $error("PC moved while the core is halted.");

endmodule

bind npc_core npc_core_assert u_npc_core_assert (
  .i_clk    (i_clk),
  .i_rst_n  (i_rst_n),
  .i_pc     (o_pc),
  .i_retire (o_retire),
  .i_halt   (o_halt)
);

// File: bench/npc_core_tb.sv
// Testbench for the NPC core that serves a program from a table and checks the retire trace.

module npc_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import npc_pkg::*;

  typedef struct packed {
    xlen_t    pc;
    logic     halt;
    logic     en;
    reg_idx_t rd;
    xlen_t    data;
  } step_t;

  localparam inst_t      EBREAK     = 32'h0010_0073;
  localparam inst_t      NOP        = 32'h0000_0013;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JALR   = 7'h67;

  logic    clk;
  logic    rst_n;
  inst_t   inst;
  xlen_t   pc;
  retire_t retire;
  logic    halt;

  inst_t prog_a [$];
  inst_t prog_b [$];
  step_t trace [$];
  int    run_sel;
  int    run_split;
  int    n_checks;
  int    n_errors;

  npc_core #(
    .RESET_PC   (64'h0),
    .DMEM_BYTES (256)
  ) u_npc_core (
    .i_clk    (clk),
    .i_rst_n  (rst_n),
    .i_inst   (inst),
    .o_pc     (pc),
    .o_retire (retire),
    .o_halt   (halt)
  );

  always #4 clk = ~clk;

  // ****************************************
  // Instruction encoders
  // ****************************************

  function automatic inst_t enc_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic inst_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
  endfunction

  function automatic inst_t enc_s(logic [2:0] f3, int rs1, int rs2, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
  endfunction

  function automatic inst_t enc_b(logic [2:0] f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic inst_t enc_u(logic [6:0] opc, int rd, int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic inst_t enc_j(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic void add_step(xlen_t exp_pc, logic exp_halt, logic exp_en, int rd,
                                   xlen_t data);
    step_t s;
    s.pc   = exp_pc;
    s.halt = exp_halt;
    s.en   = exp_en;
    s.rd   = reg_idx_t'(rd);
    s.data = data;
    trace.push_back(s);
  endfunction

  // Past the end of the program the core sees EBREAK.
  function automatic inst_t fetch(xlen_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (run_sel == 0) begin
      return (idx < prog_a.size()) ? prog_a[idx] : EBREAK;
    end
    return (idx < prog_b.size()) ? prog_b[idx] : EBREAK;
  endfunction

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic reset_core(int run);
    @(posedge clk);
    #1;
    rst_n   = 1'b0;
    run_sel = run;
    // The PC sits at zero during reset, so the core sees the first table entry.
    inst    = fetch('0);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    inst  = fetch(pc);
  endtask

  task automatic run_trace(int first, int last);
    step_t s;
    for (int i = first; i < last; i++) begin
      s = trace[i];
      @(negedge clk);
      check("o_pc", pc, s.pc);
      check("o_halt", 64'(halt), 64'(s.halt));
      check("o_retire.en", 64'(retire.en), 64'(s.en));
      if (s.en) begin
        check("o_retire.rd", 64'(retire.rd), 64'(s.rd));
        check("o_retire.data", retire.data, s.data);
      end
      @(posedge clk);
      #1;
      inst = fetch(pc);
    end
  endtask

  initial begin
    #1;
    #((trace.size() + 20) * 8);
    $display("Timeout: the core did not reach the end of the expected trace in time.");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    inst_t skip_inst;
    clk       = 1'b0;
    rst_n     = 1'b0;
    inst      = NOP;
    run_sel   = 0;
    n_checks  = 0;
    n_errors  = 0;
    skip_inst = enc_i(OPC_OP_IMM, 3'd0, 24, 0, 99);

    // ****************************************
    // Program tables
    // ****************************************

    prog_a.push_back(enc_u(OPC_LUI, 1, 'h12345));
    prog_a.push_back(enc_u(OPC_LUI, 2, 'h80000));
    prog_a.push_back(enc_u(OPC_AUIPC, 3, 1));
    prog_a.push_back(enc_i(OPC_OP_IMM, 3'd0, 4, 0, -5));
    prog_a.push_back(enc_i(OPC_OP_IMM, 3'd7, 5, 4, 'hf0));
    prog_a.push_back(enc_i(OPC_OP_IMM, 3'd6, 6, 4, 4));
    prog_a.push_back(enc_i(OPC_OP_IMM, 3'd4, 7, 4, -1));
    prog_a.push_back(enc_i(OPC_OP_IMM, 3'd2, 8, 4, -4));
    prog_a.push_back(enc_r(7'h00, 3'd0, 9, 4, 1));
    prog_a.push_back(enc_r(7'h20, 3'd0, 10, 4, 1));
    prog_a.push_back(enc_r(7'h00, 3'd7, 11, 9, 5));
    prog_a.push_back(enc_r(7'h00, 3'd6, 12, 2, 5));
    prog_a.push_back(enc_r(7'h00, 3'd4, 13, 4, 6));
    prog_a.push_back(enc_r(7'h00, 3'd2, 14, 2, 4));
    prog_a.push_back(enc_r(7'h00, 3'd2, 15, 4, 2));
    // Write to x0, then read it back through an ADD.
    prog_a.push_back(enc_i(OPC_OP_IMM, 3'd0, 0, 1, 1));
    prog_a.push_back(enc_r(7'h00, 3'd0, 16, 0, 13));
    prog_a.push_back(enc_i(OPC_OP_IMM, 3'd0, 17, 0, 64));
    prog_a.push_back(enc_s(3'd3, 17, 9, 0));
    prog_a.push_back(enc_s(3'd2, 17, 10, 8));
    prog_a.push_back(enc_s(3'd0, 17, 4, 3));
    prog_a.push_back(enc_i(OPC_LOAD, 3'd3, 18, 17, 0));
    prog_a.push_back(enc_i(OPC_LOAD, 3'd2, 19, 17, 8));
    prog_a.push_back(enc_i(OPC_LOAD, 3'd0, 20, 17, 3));
    prog_a.push_back(enc_i(OPC_LOAD, 3'd4, 21, 17, 3));
    prog_a.push_back(enc_i(OPC_LOAD, 3'd2, 22, 17, 0));
    prog_a.push_back(enc_b(3'd0, 13, 16, 8));
    prog_a.push_back(skip_inst);
    prog_a.push_back(enc_b(3'd1, 13, 16, 8));
    prog_a.push_back(enc_b(3'd4, 4, 13, 8));
    prog_a.push_back(skip_inst);
    prog_a.push_back(enc_b(3'd5, 4, 13, 8));
    prog_a.push_back(enc_b(3'd4, 13, 4, 8));
    prog_a.push_back(enc_b(3'd5, 13, 4, 8));
    prog_a.push_back(skip_inst);
    prog_a.push_back(enc_b(3'd0, 4, 13, 8));
    prog_a.push_back(enc_b(3'd1, 4, 13, 8));
    prog_a.push_back(skip_inst);
    prog_a.push_back(enc_j(25, 12));
    prog_a.push_back(skip_inst);
    prog_a.push_back(skip_inst);
    prog_a.push_back(enc_i(OPC_OP_IMM, 3'd0, 26, 0, 173));
    prog_a.push_back(enc_i(OPC_JALR, 3'd0, 27, 26, 4));
    prog_a.push_back(skip_inst);
    prog_a.push_back(EBREAK);

    prog_b.push_back(enc_i(OPC_OP_IMM, 3'd0, 1, 0, 5));
    prog_b.push_back(32'h0000_007f);
    prog_b.push_back(skip_inst);

    // ****************************************
    // Expected trace
    // ****************************************

    add_step(0, 0, 1, 1, 64'h0000_0000_1234_5000);
    add_step(4, 0, 1, 2, 64'hffff_ffff_8000_0000);
    add_step(8, 0, 1, 3, 64'h0000_0000_0000_1008);
    add_step(12, 0, 1, 4, 64'hffff_ffff_ffff_fffb);
    add_step(16, 0, 1, 5, 64'h0000_0000_0000_00f0);
    add_step(20, 0, 1, 6, 64'hffff_ffff_ffff_ffff);
    add_step(24, 0, 1, 7, 64'h0000_0000_0000_0004);
    add_step(28, 0, 1, 8, 64'h0000_0000_0000_0001);
    add_step(32, 0, 1, 9, 64'h0000_0000_1234_4ffb);
    add_step(36, 0, 1, 10, 64'hffff_ffff_edcb_affb);
    add_step(40, 0, 1, 11, 64'h0000_0000_0000_00f0);
    add_step(44, 0, 1, 12, 64'hffff_ffff_8000_00f0);
    add_step(48, 0, 1, 13, 64'h0000_0000_0000_0004);
    add_step(52, 0, 1, 14, 64'h0000_0000_0000_0001);
    add_step(56, 0, 1, 15, 64'h0000_0000_0000_0000);
    add_step(60, 0, 0, 0, 64'h0);
    add_step(64, 0, 1, 16, 64'h0000_0000_0000_0004);
    add_step(68, 0, 1, 17, 64'h0000_0000_0000_0040);
    add_step(72, 0, 0, 0, 64'h0);
    add_step(76, 0, 0, 0, 64'h0);
    add_step(80, 0, 0, 0, 64'h0);
    // The byte store replaced only byte 3 of the doubleword at 0x40.
    add_step(84, 0, 1, 18, 64'h0000_0000_fb34_4ffb);
    add_step(88, 0, 1, 19, 64'hffff_ffff_edcb_affb);
    add_step(92, 0, 1, 20, 64'hffff_ffff_ffff_fffb);
    add_step(96, 0, 1, 21, 64'h0000_0000_0000_00fb);
    add_step(100, 0, 1, 22, 64'hffff_ffff_fb34_4ffb);
    add_step(104, 0, 0, 0, 64'h0);
    add_step(112, 0, 0, 0, 64'h0);
    add_step(116, 0, 0, 0, 64'h0);
    add_step(124, 0, 0, 0, 64'h0);
    add_step(128, 0, 0, 0, 64'h0);
    add_step(132, 0, 0, 0, 64'h0);
    add_step(140, 0, 0, 0, 64'h0);
    add_step(144, 0, 0, 0, 64'h0);
    add_step(152, 0, 1, 25, 64'h0000_0000_0000_009c);
    add_step(164, 0, 1, 26, 64'h0000_0000_0000_00ad);
    add_step(168, 0, 1, 27, 64'h0000_0000_0000_00ac);
    add_step(176, 0, 0, 0, 64'h0);
    add_step(176, 1, 0, 0, 64'h0);
    add_step(176, 1, 0, 0, 64'h0);
    add_step(176, 1, 0, 0, 64'h0);
    run_split = trace.size();
    add_step(0, 0, 1, 1, 64'h0000_0000_0000_0005);
    add_step(4, 0, 0, 0, 64'h0);
    add_step(4, 1, 0, 0, 64'h0);
    add_step(4, 1, 0, 0, 64'h0);

    reset_core(0);
    run_trace(0, run_split);
    reset_core(1);
    run_trace(run_split, trace.size());

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# Builds the NPC core testbench with Verilator, runs it and checks the verdict.
verilator --binary --timing --assert -f src.f --top-module npc_core_tb -o npc_core_sim || exit 1
out=$(./obj_dir/npc_core_sim)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1

// File: src.f
verilog/npc_pkg.sv
verilog/npc_ifu.sv
verilog/npc_idu.sv
verilog/npc_bru.sv
verilog/npc_exu.sv
verilog/npc_lsu.sv
verilog/npc_core.sv
bench/npc_core_assert.sv
bench/npc_core_tb.sv

// File: verilog/npc_bru.sv
// NPC branch unit: evaluates branch conditions and selects the next program counter.

module npc_bru (
  input  npc_pkg::xlen_t i_pc,
  input  npc_pkg::xlen_t i_rs1_data,
  input  npc_pkg::xlen_t i_imm,
  input  npc_pkg::ctrl_t i_ctrl,
  input  logic           i_zero,
  input  logic           i_less,
  output npc_pkg::xlen_t o_next_pc
);

  import npc_pkg::*;

  logic  taken;
  xlen_t jalr_target;

  assign jalr_target = (i_rs1_data + i_imm) & ~xlen_t'(1);

  always_comb begin
    case (i_ctrl.br_func)
      BR_JAL:  taken = 1'b1;
      BR_BEQ:  taken = i_zero;
      BR_BNE:  taken = !i_zero;
      BR_BLT:  taken = i_less;
      BR_BGE:  taken = !i_less;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_ctrl.br_func == BR_JALR) begin
      o_next_pc = jalr_target;
    end else if (taken) begin
      o_next_pc = i_pc + i_imm;
    end else begin
      o_next_pc = i_pc + xlen_t'(4);
    end
  end

endmodule

// File: verilog/npc_core.sv
// NPC core top level: single-cycle RV64I subset built from fetch, decode, branch, execute and memory units.

module npc_core #(
  parameter npc_pkg::xlen_t RESET_PC   = '0,
  parameter int             DMEM_BYTES = 256
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  npc_pkg::inst_t   i_inst,
  output npc_pkg::xlen_t   o_pc,
  output npc_pkg::retire_t o_retire,
  output logic             o_halt
);

  import npc_pkg::*;

  ctrl_t ctrl;
  xlen_t next_pc;
  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t imm;
  xlen_t alu_result;
  xlen_t wb_data;
  xlen_t load_data;
  logic  alu_zero;
  logic  alu_less;

  npc_ifu #(
    .RESET_PC(RESET_PC)
  ) u_ifu (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_next_pc  (next_pc),
    .i_halt_req (ctrl.halt),
    .o_pc       (o_pc),
    .o_halted   (o_halt)
  );

  npc_idu u_idu (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_inst     (i_inst),
    .i_halted   (o_halt),
    .i_wb_data  (wb_data),
    .o_ctrl     (ctrl),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .o_imm      (imm),
    .o_retire   (o_retire)
  );

  npc_bru u_bru (
    .i_pc       (o_pc),
    .i_rs1_data (rs1_data),
    .i_imm      (imm),
    .i_ctrl     (ctrl),
    .i_zero     (alu_zero),
    .i_less     (alu_less),
    .o_next_pc  (next_pc)
  );

  npc_exu u_exu (
    .i_pc         (o_pc),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_imm        (imm),
    .i_ctrl       (ctrl),
    .i_load_data  (load_data),
    .o_alu_result (alu_result),
    .o_wb_data    (wb_data),
    .o_zero       (alu_zero),
    .o_less       (alu_less)
  );

  // The ALU sum of rs1 and the offset is the memory address.
  npc_lsu #(
    .DMEM_BYTES(DMEM_BYTES)
  ) u_lsu (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_addr   (alu_result),
    .i_wdata  (rs2_data),
    .i_ctrl   (ctrl),
    .i_halted (o_halt),
    .o_rdata  (load_data)
  );

endmodule

// File: verilog/npc_exu.sv
// NPC execute unit: operand selection, ALU and the register writeback multiplexer.

module npc_exu (
  input  npc_pkg::xlen_t i_pc,
  input  npc_pkg::xlen_t i_rs1_data,
  input  npc_pkg::xlen_t i_rs2_data,
  input  npc_pkg::xlen_t i_imm,
  input  npc_pkg::ctrl_t i_ctrl,
  input  npc_pkg::xlen_t i_load_data,
  output npc_pkg::xlen_t o_alu_result,
  output npc_pkg::xlen_t o_wb_data,
  output logic           o_zero,
  output logic           o_less
);

  import npc_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  logic  less;

  assign op_a = i_ctrl.alu_a_pc  ? i_pc  : i_rs1_data;
  assign op_b = i_ctrl.alu_b_imm ? i_imm : i_rs2_data;

  assign less = $signed(op_a) < $signed(op_b);

  // ****************************************
  // ALU
  // ****************************************

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:    o_alu_result = op_a + op_b;
      ALU_SUB:    o_alu_result = op_a - op_b;
      ALU_AND:    o_alu_result = op_a & op_b;
      ALU_OR:     o_alu_result = op_a | op_b;
      ALU_XOR:    o_alu_result = op_a ^ op_b;
      ALU_SLT:    o_alu_result = {63'b0, less};
      ALU_PASS_B: o_alu_result = op_b;
      default:    o_alu_result = '0;
    endcase
  end

  assign o_zero = (o_alu_result == '0);
  assign o_less = less;

  always_comb begin
    case (i_ctrl.wb_sel)
      WB_LOAD: o_wb_data = i_load_data;
      WB_PC4:  o_wb_data = i_pc + xlen_t'(4);
      default: o_wb_data = o_alu_result;
    endcase
  end

endmodule

// File: verilog/npc_idu.sv
// NPC decode unit: instruction decoder, immediate generator and integer register file.

module npc_idu (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  npc_pkg::inst_t   i_inst,
  input  logic             i_halted,
  input  npc_pkg::xlen_t   i_wb_data,
  output npc_pkg::ctrl_t   o_ctrl,
  output npc_pkg::xlen_t   o_rs1_data,
  output npc_pkg::xlen_t   o_rs2_data,
  output npc_pkg::xlen_t   o_imm,
  output npc_pkg::retire_t o_retire
);

  import npc_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  logic       illegal;
  logic       rf_we;
  xlen_t      regs [1:31];

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign rs1    = i_inst[19:15];
  assign rs2    = i_inst[24:20];
  assign rd     = i_inst[11:7];

  // ****************************************
  // Decoder and immediates
  // ****************************************

  always_comb begin
    o_ctrl  = '0;
    o_imm   = {{52{i_inst[31]}}, i_inst[31:20]};
    illegal = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        o_ctrl.alu_a_pc  = (opcode == OPC_AUIPC);
        o_ctrl.alu_b_imm = 1'b1;
        o_ctrl.alu_op    = (opcode == OPC_AUIPC) ? ALU_ADD : ALU_PASS_B;
        o_ctrl.reg_wr    = 1'b1;
        o_imm            = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
      end
      OPC_JAL: begin
        o_ctrl.br_func = BR_JAL;
        o_ctrl.wb_sel  = WB_PC4;
        o_ctrl.reg_wr  = 1'b1;
        o_imm = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      end
      OPC_JALR: begin
        o_ctrl.br_func = BR_JALR;
        o_ctrl.wb_sel  = WB_PC4;
        o_ctrl.reg_wr  = 1'b1;
        illegal        = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_imm = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
        case (funct3)
          3'b000: o_ctrl.br_func = BR_BEQ;
          3'b001: o_ctrl.br_func = BR_BNE;
          3'b100: o_ctrl.br_func = BR_BLT;
          3'b101: o_ctrl.br_func = BR_BGE;
          default: illegal = 1'b1;
        endcase
        // Equality tests look at a difference, ordering tests at a signed compare.
        o_ctrl.alu_op = funct3[2] ? ALU_SLT : ALU_SUB;
      end
      OPC_LOAD: begin
        o_ctrl.alu_b_imm = 1'b1;
        o_ctrl.mem_re    = 1'b1;
        o_ctrl.wb_sel    = WB_LOAD;
        o_ctrl.reg_wr    = 1'b1;
        case (funct3)
          3'b000: o_ctrl.mem_op = MEM_B;
          3'b100: o_ctrl.mem_op = MEM_BU;
          3'b010: o_ctrl.mem_op = MEM_W;
          3'b011: o_ctrl.mem_op = MEM_D;
          default: illegal = 1'b1;
        endcase
      end
      OPC_STORE: begin
        o_ctrl.alu_b_imm = 1'b1;
        o_ctrl.mem_wr    = 1'b1;
        o_imm            = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
        case (funct3)
          3'b000: o_ctrl.mem_op = MEM_B;
          3'b010: o_ctrl.mem_op = MEM_W;
          3'b011: o_ctrl.mem_op = MEM_D;
          default: illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM, OPC_OP: begin
        o_ctrl.alu_b_imm = (opcode == OPC_OP_IMM);
        o_ctrl.reg_wr    = 1'b1;
        case (funct3)
          3'b000: o_ctrl.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b111: o_ctrl.alu_op = ALU_AND;
          3'b110: o_ctrl.alu_op = ALU_OR;
          3'b100: o_ctrl.alu_op = ALU_XOR;
          3'b010: o_ctrl.alu_op = ALU_SLT;
          default: illegal = 1'b1;
        endcase
        if (opcode == OPC_OP && funct7 != 7'b0000000) begin
          illegal = !(funct7 == 7'b0100000 && funct3 == 3'b000);
        end
      end
      // EBREAK and every other encoding stop the core.
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      o_ctrl      = '0;
      o_ctrl.halt = 1'b1;
    end
  end

  // ****************************************
  // Register file
  // ****************************************

  assign rf_we = o_ctrl.reg_wr && (rd != '0) && !i_halted && i_rst_n;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we) begin
      regs[rd] <= i_wb_data;
    end
  end

  assign o_rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign o_rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  assign o_retire = '{en: rf_we, rd: rd, data: i_wb_data};

endmodule

// File: verilog/npc_ifu.sv
// NPC fetch unit: program counter register with next-PC load and a sticky halt flag.

module npc_ifu #(
  parameter npc_pkg::xlen_t RESET_PC = '0
) (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  npc_pkg::xlen_t i_next_pc,
  input  logic           i_halt_req,
  output npc_pkg::xlen_t o_pc,
  output logic           o_halted
);

  import npc_pkg::*;

  xlen_t pc_q;
  logic  halted_q;

  // A halt request freezes the PC at the halting instruction.
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q     <= RESET_PC;
      halted_q <= 1'b0;
    end else if (!halted_q) begin
      if (i_halt_req) begin
        halted_q <= 1'b1;
      end else begin
        pc_q <= i_next_pc;
      end
    end
  end

  assign o_pc     = pc_q;
  assign o_halted = halted_q;

endmodule

// File: verilog/npc_lsu.sv
// NPC load/store unit: little-endian byte memory with sized stores and extending loads.

module npc_lsu #(
  parameter int DMEM_BYTES = 256
) (
  input  logic           i_clk,
  input  logic           i_rst_n,
  input  npc_pkg::xlen_t i_addr,
  input  npc_pkg::xlen_t i_wdata,
  input  npc_pkg::ctrl_t i_ctrl,
  input  logic           i_halted,
  output npc_pkg::xlen_t o_rdata
);

  import npc_pkg::*;

  localparam int AW = $clog2(DMEM_BYTES);

  logic [7:0]    mem [DMEM_BYTES];
  logic [AW-1:0] byte_idx [8];
  logic [3:0]    nbytes;
  xlen_t         dword;

  // Consecutive bytes wrap around the end of the memory.
  always_comb begin
    for (int k = 0; k < 8; k++) begin
      byte_idx[k]     = i_addr[AW-1:0] + AW'(k);
      dword[8*k +: 8] = mem[byte_idx[k]];
    end
  end

  always_comb begin
    case (i_ctrl.mem_op)
      MEM_W:   nbytes = 4'd4;
      MEM_D:   nbytes = 4'd8;
      default: nbytes = 4'd1;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < DMEM_BYTES; k++) begin
        mem[k] <= '0;
      end
    end else if (i_ctrl.mem_wr && !i_halted) begin
      for (int k = 0; k < 8; k++) begin
        if (k < int'(nbytes)) begin
          mem[byte_idx[k]] <= i_wdata[8*k +: 8];
        end
      end
    end
  end

  always_comb begin
    if (!i_ctrl.mem_re) begin
      o_rdata = '0;
    end else begin
      case (i_ctrl.mem_op)
        MEM_B:   o_rdata = {{56{dword[7]}}, dword[7:0]};
        MEM_BU:  o_rdata = {56'b0, dword[7:0]};
        MEM_W:   o_rdata = {{32{dword[31]}}, dword[31:0]};
        default: o_rdata = dword;
      endcase
    end
  end

endmodule

// File: verilog/npc_pkg.sv
// NPC shared types: data widths, operation encodings and the decoder and retire structs.

package npc_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // ****************************************
  // Operation selectors
  // ****************************************

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE
  } br_func_e;

  typedef enum logic [1:0] {
    MEM_B,
    MEM_BU,
    MEM_W,
    MEM_D
  } mem_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_e;

  // ****************************************
  // Bundles between the units
  // ****************************************

  typedef struct packed {
    logic     alu_a_pc;
    logic     alu_b_imm;
    alu_op_e  alu_op;
    br_func_e br_func;
    logic     mem_wr;
    logic     mem_re;
    mem_op_e  mem_op;
    wb_sel_e  wb_sel;
    logic     reg_wr;
    logic     halt;
  } ctrl_t;

  typedef struct packed {
    logic     en;
    reg_idx_t rd;
    xlen_t    data;
  } retire_t;

endpackage
